// ==== Makefile ====
TOP := execTb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f all.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f all.f --top-module $(TOP) -Mdir obj_dir
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "All tests passed"

clean:
	rm -rf obj_dir

// ==== all.f ====
+incdir+hw
hw/aluPkg.sv
hw/aluDecoder.sv
hw/adder64.sv
hw/barrelShifter.sv
hw/alu.sv
hw/execUnit.sv
hw/execTop.sv
verification/execTb.sv

// ==== hw/adder64.sv ====
// Full-width adder of the ALU; also serves subtract and compare with b pre-inverted.
`include "alu_config.svh"

module adder64 (
    input  aluPkg::word_t a,
    input  aluPkg::word_t b,
    input  logic          cin,
    output aluPkg::word_t sum,
    output logic          carry,
    output logic          overflow,
    output logic          sign,
    output logic          zero
);

    localparam int Msb = `ALU_XLEN - 1;

    logic [`ALU_XLEN:0] wide; // Extra bit holds the carry-out.

    assign wide = {1'b0, a} + {1'b0, b} + {{`ALU_XLEN{1'b0}}, cin};

    assign sum   = wide[Msb:0];
    assign carry = wide[`ALU_XLEN];

    // Same-signed inputs giving a result of the other sign.
    assign overflow = (a[Msb] == b[Msb]) && (sum[Msb] != a[Msb]);

    assign sign = sum[Msb];
    assign zero = (sum == '0);

endmodule

// ==== hw/alu.sv ====
// Combinational integer ALU; decodes the operation and selects one datapath result.
module alu (
    input  aluPkg::aluOp_t aluOp,
    input  aluPkg::word_t  opA,
    input  aluPkg::word_t  opB,
    output aluPkg::word_t  result,
    output logic           zero
);

    logic           subtract;
    logic           signedCmp;
    logic           arith;
    logic           shiftRight;
    aluPkg::opSel_t opSel;

    aluPkg::word_t  adderB;
    aluPkg::word_t  sum;
    logic           carry;
    logic           overflow;
    logic           sign;
    aluPkg::word_t  shifted;
    logic           cmpBit;

    aluDecoder decoder0 (
        .aluOp      (aluOp),
        .subtract   (subtract),
        .signedCmp  (signedCmp),
        .arith      (arith),
        .shiftRight (shiftRight),
        .opSel      (opSel)
    );

    assign adderB = subtract ? ~opB : opB; // Two's complement with cin.

    adder64 adder0 (
        .a        (opA),
        .b        (adderB),
        .cin      (subtract),
        .sum      (sum),
        .carry    (carry),
        .overflow (overflow),
        .sign     (sign),
        .zero     (zero)
    );

    barrelShifter shifter0 (
        .data       (opA),
        .shamt      (aluPkg::shamt_t'(opB)),
        .shiftRight (shiftRight),
        .arith      (arith),
        .shifted    (shifted)
    );

    // No borrow means a >= b for the unsigned case.
    assign cmpBit = signedCmp ? (overflow ^ sign) : ~carry;

    always_comb begin
        case (opSel)
            aluPkg::SEL_AND:   result = opA & opB;
            aluPkg::SEL_OR:    result = opA | opB;
            aluPkg::SEL_XOR:   result = opA ^ opB;
            aluPkg::SEL_SHIFT: result = shifted;
            aluPkg::SEL_PASSB: result = opB;
            aluPkg::SEL_CMP:   result = aluPkg::word_t'(cmpBit);
            default:           result = sum;
        endcase
    end

    // A clean opcode must give a clean mux select out of the decoder.
    always_comb begin
        if (!$isunknown(aluOp)) begin
            assert (!$isunknown(opSel))
                else $error("ALU select unknown for opcode %h", aluOp);
        end
    end

endmodule

// ==== hw/aluDecoder.sv ====
// Control decoder of the ALU; maps an operation code to adder, shifter and mux controls.
module aluDecoder (
    input  aluPkg::aluOp_t aluOp,
    output logic           subtract,
    output logic           signedCmp,
    output logic           arith,
    output logic           shiftRight,
    output aluPkg::opSel_t opSel
);

    always_comb begin
        subtract   = 1'b0;
        signedCmp  = 1'b0;
        arith      = 1'b0;
        shiftRight = 1'b0;
        opSel      = aluPkg::SEL_ADD; // Undefined codes fall through as add.
        case (aluOp)
            aluPkg::OP_SLL: begin
                opSel = aluPkg::SEL_SHIFT;
            end
            aluPkg::OP_SLT: begin
                subtract  = 1'b1;
                signedCmp = 1'b1;
                opSel     = aluPkg::SEL_CMP;
            end
            aluPkg::OP_SLTU: begin
                subtract = 1'b1;
                opSel    = aluPkg::SEL_CMP;
            end
            aluPkg::OP_XOR: begin
                opSel = aluPkg::SEL_XOR;
            end
            aluPkg::OP_SRL: begin
                shiftRight = 1'b1;
                opSel      = aluPkg::SEL_SHIFT;
            end
            aluPkg::OP_OR: begin
                opSel = aluPkg::SEL_OR;
            end
            aluPkg::OP_AND: begin
                opSel = aluPkg::SEL_AND;
            end
            aluPkg::OP_SUB: begin
                subtract = 1'b1;
            end
            aluPkg::OP_SRA: begin
                arith      = 1'b1;
                shiftRight = 1'b1;
                opSel      = aluPkg::SEL_SHIFT;
            end
            aluPkg::OP_PASSB: begin
                opSel = aluPkg::SEL_PASSB;
            end
            default: begin
                opSel = aluPkg::SEL_ADD;
            end
        endcase
    end

endmodule

// ==== hw/aluPkg.sv ====
// Shared vector types and operation encodings for the ALU and its control decoder.
`include "alu_config.svh"

package aluPkg;

    typedef logic [`ALU_XLEN-1:0]    word_t;
    typedef logic [`ALU_OP_W-1:0]    aluOp_t;
    typedef logic [`ALU_SHAMT_W-1:0] shamt_t;
    typedef logic [`ALU_SEL_W-1:0]   opSel_t;

    // Operation codes.
    localparam aluOp_t OP_ADD   = 4'b0000;
    localparam aluOp_t OP_SLL   = 4'b0001;
    localparam aluOp_t OP_SLT   = 4'b0010;
    localparam aluOp_t OP_SLTU  = 4'b0011;
    localparam aluOp_t OP_XOR   = 4'b0100;
    localparam aluOp_t OP_SRL   = 4'b0101;
    localparam aluOp_t OP_OR    = 4'b0110;
    localparam aluOp_t OP_AND   = 4'b0111;
    localparam aluOp_t OP_SUB   = 4'b1000;
    localparam aluOp_t OP_SRA   = 4'b1101;
    localparam aluOp_t OP_PASSB = 4'b1111;

    // Result multiplexer inputs.
    localparam opSel_t SEL_ADD   = 3'd0;
    localparam opSel_t SEL_AND   = 3'd1;
    localparam opSel_t SEL_OR    = 3'd2;
    localparam opSel_t SEL_XOR   = 3'd3;
    localparam opSel_t SEL_SHIFT = 3'd4;
    localparam opSel_t SEL_PASSB = 3'd5;
    localparam opSel_t SEL_CMP   = 3'd6;

endpackage

// ==== hw/alu_config.svh ====
// Width macros for the execute block; include in any file that sizes vectors from them.
`ifndef ALU_CONFIG_SVH
`define ALU_CONFIG_SVH

// Data word of the RV64 datapath.
`define ALU_XLEN 64

// ALU operation code as carried from the decode stage.
`define ALU_OP_W 4

// Shift amount taken from the low bits of operand b.
`define ALU_SHAMT_W 6

// Result multiplexer select.
`define ALU_SEL_W 3

`endif

// ==== hw/barrelShifter.sv ====
// Logarithmic shifter of the ALU for sll, srl and sra; left shifts reuse the right datapath.
`include "alu_config.svh"

module barrelShifter (
    input  aluPkg::word_t  data,
    input  aluPkg::shamt_t shamt,
    input  logic           shiftRight,
    input  logic           arith,
    output aluPkg::word_t  shifted
);

    aluPkg::word_t stage [0:`ALU_SHAMT_W];
    logic          fill;

    function automatic aluPkg::word_t reverseBits(input aluPkg::word_t v);
        aluPkg::word_t r;
        for (int i = 0; i < `ALU_XLEN; i++) begin
            r[i] = v[`ALU_XLEN-1-i];
        end
        return r;
    endfunction

    // Sign fill only for sra.
    assign fill = arith & shiftRight & data[`ALU_XLEN-1];

    assign stage[0] = shiftRight ? data : reverseBits(data);

    for (genvar s = 0; s < `ALU_SHAMT_W; s++) begin : gStage
        localparam int step = 1 << s;

        assign stage[s+1] = shamt[s] ? {{step{fill}}, stage[s][`ALU_XLEN-1:step]}
                                     : stage[s];
    end

    assign shifted = shiftRight ? stage[`ALU_SHAMT_W] : reverseBits(stage[`ALU_SHAMT_W]);

endmodule

// ==== hw/execTop.sv ====
// Top level of the execute block; exposes the req/ack handshake of the execute unit.
module execTop (
    input  logic           clk,
    input  logic           rstN,
    input  logic           req,
    input  aluPkg::aluOp_t aluOp,
    input  aluPkg::word_t  opA,
    input  aluPkg::word_t  opB,
    output logic           ack,
    output aluPkg::word_t  result,
    output logic           zero
);

    // Straight connection; all timing lives in the unit.
    execUnit unit0 (
        .clk    (clk),
        .rstN   (rstN),
        .req    (req),
        .aluOp  (aluOp),
        .opA    (opA),
        .opB    (opB),
        .ack    (ack),
        .result (result),
        .zero   (zero)
    );

endmodule

// ==== hw/execUnit.sv ====
// Four-phase req/ack execute unit; latches a request, runs the ALU and returns the result.
module execUnit (
    input  logic           clk,
    input  logic           rstN,
    input  logic           req,
    input  aluPkg::aluOp_t aluOp,
    input  aluPkg::word_t  opA,
    input  aluPkg::word_t  opB,
    output logic           ack,
    output aluPkg::word_t  result,
    output logic           zero
);

    typedef enum logic [1:0] {
        Idle,
        Busy,
        Done
    } state_t;

    state_t         state;
    aluPkg::aluOp_t opLatch;
    aluPkg::word_t  aLatch;
    aluPkg::word_t  bLatch;
    aluPkg::word_t  aluResult;
    logic           aluZero;

    alu alu0 (
        .aluOp  (opLatch),
        .opA    (aLatch),
        .opB    (bLatch),
        .result (aluResult),
        .zero   (aluZero)
    );

    // Operands captured when a request is accepted.
    always_ff @(posedge clk) begin
        if (state == Idle && req) begin
            opLatch <= aluOp;
            aLatch  <= opA;
            bLatch  <= opB;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            state  <= Idle;
            ack    <= 1'b0;
            result <= '0;
            zero   <= 1'b0;
        end else begin
            case (state)
                Idle: begin
                    if (req) state <= Busy;
                end
                Busy: begin
                    result <= aluResult;
                    zero   <= aluZero;
                    ack    <= 1'b1;
                    state  <= Done;
                end
                Done: begin
                    if (!req) begin
                        ack   <= 1'b0; // Release once the requester has let go.
                        state <= Idle;
                    end
                end
                default: state <= Idle;
            endcase
        end
    end

    ackNeedsReq: assert property (@(posedge clk) disable iff (!rstN)
        $rose(ack) |-> req);

    resultHeld: assert property (@(posedge clk) disable iff (!rstN)
        (ack && $past(ack)) |-> ($stable(result) && $stable(zero)));

    ackReleases: assert property (@(posedge clk) disable iff (!rstN)
        $fell(req) |=> !ack);

endmodule

// ==== verification/aluCases.mem ====
// Columns: opcode, operand a, operand b, expected result, expected zero flag (hex).
// Zero follows the adder sum, so it means a == b for sub, slt and sltu.
0 0000000000000001 0000000000000002 0000000000000003 0
0 ffffffffffffffff 0000000000000001 0000000000000000 1
0 7fffffffffffffff 0000000000000001 8000000000000000 0
0 0123456789abcdef 1111111111111111 123456789abcdf00 0
8 0000000000000005 0000000000000005 0000000000000000 1
8 0000000000000000 0000000000000001 ffffffffffffffff 0
8 8000000000000000 0000000000000001 7fffffffffffffff 0
8 0000000000001000 0000000000000001 0000000000000fff 0
f 0000000000000001 ffffffffffffffff ffffffffffffffff 1
f 0000000000000000 00000000cafef00d 00000000cafef00d 0
7 ff00ff00ff00ff00 0ff00ff00ff00ff0 0f000f000f000f00 0
6 ff00ff00ff00ff00 0ff00ff00ff00ff0 fff0fff0fff0fff0 0
4 ff00ff00ff00ff00 0ff00ff00ff00ff0 f0f0f0f0f0f0f0f0 0
7 0000000000000000 0000000000000000 0000000000000000 1
4 5555555555555555 5555555555555555 0000000000000000 0
1 0000000000000001 0000000000000000 0000000000000001 0
1 0000000000000001 0000000000000001 0000000000000002 0
1 0000000000000001 000000000000003f 8000000000000000 0
1 0000000000000001 0000000000000040 0000000000000001 0
1 0000000000000003 0000000000000041 0000000000000006 0
5 8000000000000000 0000000000000000 8000000000000000 0
5 8000000000000000 0000000000000001 4000000000000000 0
5 8000000000000000 000000000000003f 0000000000000001 0
5 ffffffffffffffff 0000000000000044 0fffffffffffffff 0
d 8000000000000000 0000000000000001 c000000000000000 0
d 8000000000000000 000000000000003f ffffffffffffffff 0
d 7fffffffffffffff 000000000000003f 0000000000000000 0
d 8000000000000010 0000000000000044 f800000000000001 0
d 0000000000000000 0000000000000000 0000000000000000 1
2 ffffffffffffffff 0000000000000001 0000000000000001 0
3 ffffffffffffffff 0000000000000001 0000000000000000 0
2 8000000000000000 7fffffffffffffff 0000000000000001 0
3 8000000000000000 7fffffffffffffff 0000000000000000 0
2 7fffffffffffffff 8000000000000000 0000000000000000 0
3 7fffffffffffffff 8000000000000000 0000000000000001 0
2 0000000000000005 0000000000000005 0000000000000000 1
3 0000000000000000 ffffffffffffffff 0000000000000001 0
3 0000000000000003 0000000000000003 0000000000000000 1
9 0000000000000002 0000000000000003 0000000000000005 0
e ffffffffffffffff 0000000000000001 0000000000000000 1
a 0000000000001000 0000000000000001 0000000000001001 0

// ==== verification/execTb.sv ====
// Testbench of the execute block; runs file and random cases over req/ack and checks results.
`include "alu_config.svh"

module execTb;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int MaxCases    = 64;
    localparam int Words       = 5;  // Opcode, a, b, result, zero.
    localparam int RandomCases = 16;
    localparam int AckLimit    = 8;
    localparam int ReleaseLimit = 2;

    logic           clk = 1'b0;
    logic           rstN;
    logic           req;
    aluPkg::aluOp_t aluOp;
    aluPkg::word_t  opA;
    aluPkg::word_t  opB;
    logic           ack;
    aluPkg::word_t  result;
    logic           zero;

    aluPkg::word_t  caseMem [0:MaxCases*Words-1];
    int             numCases  = 0;
    int             passCount = 0;
    int             failCount = 0;
    logic           loaded    = 1'b0;
    integer         seed;

    execTop dut0 (
        .clk    (clk),
        .rstN   (rstN),
        .req    (req),
        .aluOp  (aluOp),
        .opA    (opA),
        .opB    (opB),
        .ack    (ack),
        .result (result),
        .zero   (zero)
    );

    always #2 clk = ~clk;

    // Expected result and zero flag from the ISA meaning of each opcode.
    function automatic void modelAlu(input aluPkg::aluOp_t op, input aluPkg::word_t a,
                                     input aluPkg::word_t b, output aluPkg::word_t res,
                                     output logic z);
        aluPkg::word_t sum;
        aluPkg::word_t diff;
        logic [5:0]    sh;
        sum  = a + b;
        diff = a - b;
        sh   = b[5:0];
        z    = (sum == '0);
        case (op)
            aluPkg::OP_SUB: begin
                res = diff;
                z   = (diff == '0);
            end
            aluPkg::OP_SLT: begin
                res = {{(`ALU_XLEN-1){1'b0}}, $signed(a) < $signed(b)};
                z   = (diff == '0);
            end
            aluPkg::OP_SLTU: begin
                res = {{(`ALU_XLEN-1){1'b0}}, a < b};
                z   = (diff == '0);
            end
            aluPkg::OP_SLL:   res = a << sh;
            aluPkg::OP_SRL:   res = a >> sh;
            aluPkg::OP_SRA:   res = $unsigned($signed(a) >>> sh); // Sign fill.
            aluPkg::OP_XOR:   res = a ^ b;
            aluPkg::OP_OR:    res = a | b;
            aluPkg::OP_AND:   res = a & b;
            aluPkg::OP_PASSB: res = b;
            default:          res = sum;
        endcase
    endfunction

    // One full four-phase transfer with timing and value checks.
    task automatic runCase(input int idx, input aluPkg::aluOp_t op, input aluPkg::word_t a,
                           input aluPkg::word_t b, input aluPkg::word_t expRes,
                           input logic expZero);
        int            edges;
        int            hold;
        logic          ok;
        aluPkg::word_t held;
        logic          heldZero;
        ok   = 1'b1;
        hold = idx % 3; // Extra cycles with req kept high.
        @(posedge clk);
        req   <= 1'b1;
        aluOp <= op;
        opA   <= a;
        opB   <= b;
        @(posedge clk);
        edges = 1;
        @(negedge clk);
        while (ack !== 1'b1 && edges < AckLimit) begin
            @(posedge clk);
            edges++;
            @(negedge clk);
        end
        assert (ack === 1'b1) else begin
            $display("case %0d: ack did not rise within %0d cycles", idx, AckLimit);
            ok = 1'b0;
        end
        if (ack === 1'b1) begin
            assert (edges == 2) else begin
                $display("[ERROR] %0d ns ackEdges: expected %0d, got %0d", $time, 2, edges);
                ok = 1'b0;
            end
            assert (result === expRes) else begin
                $display("[ERROR] %0d ns result: expected %h, got %h", $time, expRes, result);
                ok = 1'b0;
            end
            assert (zero === expZero) else begin
                $display("[ERROR] %0d ns zero: expected %b, got %b", $time, expZero, zero);
                ok = 1'b0;
            end
            held     = result;
            heldZero = zero;
            repeat (hold) begin
                @(negedge clk);
                assert (ack === 1'b1) else begin
                    $display("case %0d: ack dropped while req was still high", idx);
                    ok = 1'b0;
                end
                assert (result === held) else begin
                    $display("[ERROR] %0d ns result: expected %h, got %h", $time, held, result);
                    ok = 1'b0;
                end
                assert (zero === heldZero) else begin
                    $display("[ERROR] %0d ns zero: expected %b, got %b", $time, heldZero, zero);
                    ok = 1'b0;
                end
            end
        end
        @(posedge clk);
        req <= 1'b0;
        edges = 0;
        do begin
            @(posedge clk);
            edges++;
            @(negedge clk);
        end while (ack !== 1'b0 && edges < ReleaseLimit + 1);
        assert (ack === 1'b0 && edges <= ReleaseLimit) else begin
            $display("case %0d: ack did not fall after req was lowered", idx);
            ok = 1'b0;
        end
        if (ok) begin
            passCount++;
            $display("case %0d op %h a %h b %h: ok", idx, op, a, b);
        end else begin
            failCount++;
            $display("case %0d op %h a %h b %h: FAIL", idx, op, a, b);
        end
    endtask

    // Watchdog sized from the number of loaded cases.
    initial begin
        wait (loaded);
        repeat ((numCases + RandomCases) * 20 + 100) @(posedge clk);
        $display("Timeout: the run did not finish in the expected number of cycles");
        $display("Some tests failed");
        $finish;
    end

    initial begin
        int            k;
        int            base;
        aluPkg::aluOp_t op;
        aluPkg::word_t a;
        aluPkg::word_t b;
        aluPkg::word_t expRes;
        logic          expZero;
        logic [31:0]   rnd;
        rstN  <= 1'b0;
        req   <= 1'b0;
        aluOp <= '0;
        opA   <= '0;
        opB   <= '0;
        seed  = 32'h0c4a_b95d;
        for (k = 0; k < MaxCases * Words; k++) begin
            caseMem[k] = {32'hdead_beef, k}; // Opcode words above f mark the end.
        end
        $readmemh("verification/aluCases.mem", caseMem);
        for (k = 0; k < MaxCases; k++) begin
            if (caseMem[k*Words] > 64'd15) break;
        end
        numCases = k;
        loaded   = 1'b1;

        repeat (2) @(posedge clk);
        rstN <= 1'b1;
        @(negedge clk);
        assert (ack === 1'b0 && result === '0 && zero === 1'b0) else begin
            $display("reset: ack, result or zero not cleared after reset");
            failCount++;
        end
        assert (numCases > 0) else begin
            $display("no cases were loaded from the case file");
            failCount++;
        end

        for (int i = 0; i < numCases; i++) begin
            base    = i * Words;
            op      = aluPkg::aluOp_t'(caseMem[base]);
            expZero = caseMem[base+4][0];
            runCase(i, op, caseMem[base+1], caseMem[base+2], caseMem[base+3], expZero);
        end

        for (int i = 0; i < RandomCases; i++) begin
            rnd = $random(seed);
            op  = rnd[3:0]; // Undefined codes included.
            a   = {$random(seed), $random(seed)};
            b   = {$random(seed), $random(seed)};
            modelAlu(op, a, b, expRes, expZero);
            runCase(numCases + i, op, a, b, expRes, expZero);
        end

        $display("tests %0d, passed %0d, failed %0d", passCount + failCount, passCount,
                 failCount);
        if (failCount == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule
